//--- Makefile
# Verilator build and trace run of the floor request controller

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the trace testbench"
	@echo "make clean  remove the Verilator build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f files.f --top-module floor_controller_tb -o floor_sim
	./obj_dir/floor_sim | awk '{ print } /^RESULT: PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- files.f
+incdir+source
source/elevator_pkg.sv
source/request_if.sv
source/request_latch.sv
source/request_queue.sv
source/dispatch_control.sv
source/floor_controller.sv
testbench/clock_gen.sv
testbench/floor_controller_tb.sv

//--- source/dispatch_control.sv
// Dispatcher of the request controller, picks the target floor and drives car move and door permits
`default_nettype none

module dispatch_control (
    input  wire                           clock,
    input  wire                           reset_n,
    input  wire elevator_pkg::car_state_t car_state,
    input  wire                           car_direction,
    input  wire elevator_pkg::floor_t     current_floor,
    input  wire                           power_switch,
    input  wire                           emergency_btn,
    input  wire                           door_open_btn,
    input  wire                           door_close_btn,
    output logic                          activate,
    output logic                          direction,
    output logic                          door_open_allowed,
    output logic                          door_close_allowed,
    output elevator_pkg::floor_t          target_floor,
    request_if.dispatch                   req
);
    import elevator_pkg::*;

    logic stopped;

    ////////////////////
    // Car status decode
    ////////////////////

    // Stop codes sit at the bottom of the state encoding
    assign stopped = (car_state <= stop_fl11);

    // Power off or emergency button clears all requests
    assign req.flush   = !power_switch || emergency_btn;
    assign req.arrived = stopped && !req.flush;

    ////////////////////
    // Target selection
    ////////////////////

    // New target only while parked, it holds during moves and flushes
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            target_floor <= '0;
        end else if (req.arrived && !req.empty) begin
            target_floor <= req.head;
        end
    end

    // Served floor leaves the queue once the car stands at it
    assign req.pop = req.arrived && !req.empty && (req.head == current_floor);

    ////////////////////
    // Car and door outputs
    ////////////////////

    assign activate = req.arrived && (target_floor != current_floor);

    // Keep the car's own heading unless a move is being requested
    assign direction = activate ? (target_floor > current_floor) : car_direction;

    // Door buttons pass through only with the car parked
    assign door_open_allowed  = door_open_btn && req.arrived;
    assign door_close_allowed = door_close_btn && req.arrived;

endmodule

`default_nettype wire

//--- source/elevator_cfg.svh
// Floor count and field widths for the elevator request controller, included wherever they are needed
`ifndef ELEVATOR_CFG_SVH
`define ELEVATOR_CFG_SVH

////////////////////
// Building size
////////////////////

// Floors served by the car, numbered from 0 at the lowest
`define FLOOR_COUNT 11

// Bits needed to carry one floor number
`define FLOOR_WIDTH 4

// Bits of the state code reported by the car state machine
`define STATE_WIDTH 6

`endif

//--- source/elevator_pkg.sv
// Shared floor types and car state codes, imported by every module of the request controller
`default_nettype none

`include "elevator_cfg.svh"

package elevator_pkg;

    // One floor number, 0 is the lowest floor
    typedef logic [`FLOOR_WIDTH-1:0] floor_t;

    // One bit per floor for buttons and lights
    typedef logic [`FLOOR_COUNT-1:0] floor_mask_t;

    // State codes of the external car state machine
    // Stops come first so that a stop decodes as a plain compare
    typedef enum logic [`STATE_WIDTH-1:0] {
        stop_fl1 = 6'h00, stop_fl2, stop_fl3, stop_fl4,
        stop_fl5, stop_fl6, stop_fl7, stop_fl8,
        stop_fl9, stop_fl10, stop_fl11,
        // Upward moves between neighbouring floors
        up_fl1_fl2 = 6'h0B, up_fl2_fl3, up_fl3_fl4, up_fl4_fl5,
        up_fl5_fl6, up_fl6_fl7, up_fl7_fl8, up_fl8_fl9,
        up_fl9_fl10, up_fl10_fl11,
        // Downward moves between neighbouring floors
        down_fl11_fl10 = 6'h15, down_fl10_fl9, down_fl9_fl8, down_fl8_fl7,
        down_fl7_fl6, down_fl6_fl5, down_fl5_fl4, down_fl4_fl3,
        down_fl3_fl2, down_fl2_fl1,
        // Car halted by its own safety logic
        emergency = 6'h1F
    } car_state_t;

endpackage

`default_nettype wire

//--- source/floor_controller.sv
// Top level of the elevator request controller, sits beside the car state machine with plain ports
`default_nettype none

module floor_controller (
    input  wire                            clock,
    input  wire                            reset_n,
    // Hall call and car panel buttons, one bit per floor
    input  wire elevator_pkg::floor_mask_t floor_call_buttons,
    input  wire elevator_pkg::floor_mask_t panel_buttons,
    input  wire                            door_open_btn,
    input  wire                            door_close_btn,
    input  wire                            emergency_btn,
    input  wire                            power_switch,
    // Status from the car state machine
    input  wire elevator_pkg::floor_t      current_floor,
    input  wire elevator_pkg::car_state_t  car_state,
    // Heading of the car, 1 means up
    input  wire                            car_direction,
    // Commands back to the car state machine
    output wire elevator_pkg::floor_t      target_floor,
    output wire                            activate,
    output wire                            direction,
    // Button lamps
    output wire elevator_pkg::floor_mask_t call_lights,
    output wire elevator_pkg::floor_mask_t panel_lights,
    output wire                            door_open_allowed,
    output wire                            door_close_allowed
);

    request_if req_bus ();

    // Button lights and new request pushes
    request_latch latch_i (
        .clock              (clock),
        .reset_n            (reset_n),
        .floor_call_buttons (floor_call_buttons),
        .panel_buttons      (panel_buttons),
        .current_floor      (current_floor),
        .call_lights        (call_lights),
        .panel_lights       (panel_lights),
        .req                (req_bus.latch)
    );

    // Pending floors in arrival order
    request_queue queue_i (
        .clock   (clock),
        .reset_n (reset_n),
        .req     (req_bus.queue)
    );

    // Target floor, move request and door permits
    dispatch_control dispatch_i (
        .clock              (clock),
        .reset_n            (reset_n),
        .car_state          (car_state),
        .car_direction      (car_direction),
        .current_floor      (current_floor),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .activate           (activate),
        .direction          (direction),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed),
        .target_floor       (target_floor),
        .req                (req_bus.dispatch)
    );

endmodule

`default_nettype wire

//--- source/request_if.sv
// Request bus between the button latch, the floor queue and the dispatcher inside the controller
`default_nettype none

interface request_if;
    import elevator_pkg::*;

    // New pending floor from the latch, one cycle strobe
    logic   push;
    floor_t push_floor;

    // Oldest pending floor and queue status
    floor_t head;
    logic   empty;

    // Served floor leaves the queue
    logic   pop;

    // Power loss or emergency clears everything
    logic   flush;
    // Car parked at a floor with no flush
    logic   arrived;

    modport latch (output push, push_floor, input flush, arrived);

    modport queue (input push, push_floor, pop, flush, arrived, output head, empty);

    modport dispatch (input head, empty, output pop, flush, arrived);

endinterface

`default_nettype wire

//--- source/request_latch.sv
// Button light latch for the request controller, turns hall and panel presses into lights and queue pushes
`default_nettype none

module request_latch (
    input  wire                       clock,
    input  wire                       reset_n,
    input  wire elevator_pkg::floor_mask_t floor_call_buttons,
    input  wire elevator_pkg::floor_mask_t panel_buttons,
    input  wire elevator_pkg::floor_t current_floor,
    output elevator_pkg::floor_mask_t call_lights,
    output elevator_pkg::floor_mask_t panel_lights,
    request_if.latch                  req
);
    import elevator_pkg::*;

    floor_mask_t here_mask;
    floor_mask_t pending;
    floor_mask_t panel_cand;
    floor_mask_t call_cand;
    floor_mask_t sel_mask;
    floor_mask_t clear_mask;
    floor_t      sel_floor;
    logic        use_panel;
    logic        sel_valid;

    // Lowest set bit of a floor mask
    function automatic floor_t lowest_floor(input floor_mask_t mask);
        floor_t idx;
        idx = '0;
        for (int i = $bits(floor_mask_t) - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = floor_t'(i);
            end
        end
        return idx;
    endfunction

    ////////////////////
    // New request pick
    ////////////////////

    assign here_mask = floor_mask_t'(1) << current_floor;
    assign pending   = call_lights | panel_lights;

    // Pressed buttons whose own light is still off, never the floor we sit at
    assign panel_cand = panel_buttons & ~panel_lights & ~here_mask;
    assign call_cand  = floor_call_buttons & ~call_lights & ~here_mask;

    // Panel wins over hall calls, lowest floor wins inside each group
    assign use_panel = |panel_cand;
    assign sel_floor = use_panel ? lowest_floor(panel_cand) : lowest_floor(call_cand);
    assign sel_valid = (use_panel || (|call_cand)) && !req.flush;
    assign sel_mask  = floor_mask_t'(1) << sel_floor;

    // Only a floor that is not yet pending goes into the queue
    assign req.push       = sel_valid && !(|(pending & sel_mask));
    assign req.push_floor = sel_floor;

    ////////////////////
    // Light registers
    ////////////////////

    // Lights of the parked floor go out on arrival
    assign clear_mask = req.arrived ? here_mask : '0;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_lights  <= '0;
            panel_lights <= '0;
        end else if (req.flush) begin
            call_lights  <= '0;
            panel_lights <= '0;
        end else begin
            panel_lights <= (panel_lights & ~clear_mask) |
                            ((sel_valid && use_panel) ? sel_mask : '0);
            call_lights  <= (call_lights & ~clear_mask) |
                            ((sel_valid && !use_panel) ? sel_mask : '0);
        end
    end

endmodule

`default_nettype wire

//--- source/request_queue.sv
// Arrival ordered floor queue of the request controller, one slot per floor so it cannot overflow
`default_nettype none

`include "elevator_cfg.svh"

module request_queue (
    input  wire      clock,
    input  wire      reset_n,
    request_if.queue req
);
    import elevator_pkg::*;

    // Slot storage, payload only
    floor_t slots [`FLOOR_COUNT];

    floor_t                  rd_ptr;
    floor_t                  wr_ptr;
    logic [`FLOOR_WIDTH-1:0] count;
    logic                    take;

    // Circular pointer advance
    function automatic floor_t bump(input floor_t ptr);
        return (ptr == floor_t'(`FLOOR_COUNT - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign req.empty = (count == '0);
    assign req.head  = slots[rd_ptr];

    // Pops only count while the car is parked and something is queued
    assign take = req.pop && req.arrived && !req.empty;

    ////////////////////
    // Storage write
    ////////////////////

    always_ff @(posedge clock) begin
        if (req.push) begin
            slots[wr_ptr] <= req.push_floor;
        end
    end

    ////////////////////
    // Pointers and count
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (req.flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (req.push) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (take) begin
                rd_ptr <= bump(rd_ptr);
            end
            // Push and pop together leave the count alone
            unique case ({req.push, take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
// Testbench clock and power-on reset source, period 10 with reset held low for 3 cycles
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset_n
);

    // Free running clock, first rising edge at time 5
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Reset low through the first 3 rising edges, released between edges
    initial begin
        reset_n = 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/floor_controller_tb.sv
// Trace driven testbench of the floor request controller, run from the project root through files.f
`default_nettype none

`include "elevator_cfg.svh"

module floor_controller_tb;
    import elevator_pkg::*;

    // Columns per trace line and room for the whole trace
    localparam int FIELDS    = 17;
    localparam int MAX_LINES = 64;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor;
    car_state_t  car_state;
    logic        car_direction;
    floor_t      target_floor;
    logic        activate;
    logic        direction;
    floor_mask_t call_lights;
    floor_mask_t panel_lights;
    logic        door_open_allowed;
    logic        door_close_allowed;

    // Flat trace image, one word per column
    logic [15:0] trace [MAX_LINES * FIELDS];

    int line_total;
    int row;
    int current_test;
    int checks;
    int errors;
    int test_errors;
    int test_cycles;
    int tests_done;

    clock_gen clock_gen_i (
        .clock   (clock),
        .reset_n (reset_n)
    );

    floor_controller floor_controller_i (
        .clock              (clock),
        .reset_n            (reset_n),
        .floor_call_buttons (floor_call_buttons),
        .panel_buttons      (panel_buttons),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .emergency_btn      (emergency_btn),
        .power_switch       (power_switch),
        .current_floor      (current_floor),
        .car_state          (car_state),
        .car_direction      (car_direction),
        .target_floor       (target_floor),
        .activate           (activate),
        .direction          (direction),
        .call_lights        (call_lights),
        .panel_lights       (panel_lights),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    ////////////////////
    // Trace access
    ////////////////////

    function automatic logic [15:0] trace_field(input int r, input int c);
        return trace[r * FIELDS + c];
    endfunction

    // Inputs of one line, taken by the DUT at the next rising edge
    task automatic drive_inputs(input int r);
        floor_call_buttons <= floor_mask_t'(trace_field(r, 1));
        panel_buttons      <= floor_mask_t'(trace_field(r, 2));
        door_open_btn      <= 1'(trace_field(r, 3));
        door_close_btn     <= 1'(trace_field(r, 4));
        emergency_btn      <= 1'(trace_field(r, 5));
        power_switch       <= 1'(trace_field(r, 6));
        current_floor      <= floor_t'(trace_field(r, 7));
        car_state          <= car_state_t'(`STATE_WIDTH'(trace_field(r, 8)));
        car_direction      <= 1'(trace_field(r, 9));
    endtask

    task automatic compare_output(input string name, input int got, input int expected);
        checks++;
        if (got != expected) begin
            errors++;
            test_errors++;
            $display("Error at time %0t: test %0d line %0d, %s is %0h, expected %0h",
                     $time, current_test, row + 1, name, got, expected);
        end
    endtask

    // Outputs against the hand worked columns of the line
    task automatic check_outputs(input int r);
        compare_output("call_lights", int'(call_lights), int'(trace_field(r, 10)));
        compare_output("panel_lights", int'(panel_lights), int'(trace_field(r, 11)));
        compare_output("target_floor", int'(target_floor), int'(trace_field(r, 12)));
        compare_output("activate", int'(activate), int'(trace_field(r, 13)));
        compare_output("direction", int'(direction), int'(trace_field(r, 14)));
        compare_output("door_open_allowed", int'(door_open_allowed), int'(trace_field(r, 15)));
        compare_output("door_close_allowed", int'(door_close_allowed), int'(trace_field(r, 16)));
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int counted;
        // Idle building, car parked at the lowest floor with power on
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        current_floor      = '0;
        car_state          = stop_fl1;
        car_direction      = 1'b0;
        // Test number 0 marks the end of the trace
        for (int i = 0; i < MAX_LINES * FIELDS; i++) begin
            trace[i] = '0;
        end
        $readmemh("testbench/floor_trace.txt", trace);
        counted = 0;
        while (counted < MAX_LINES && trace_field(counted, 0) != 0) begin
            counted++;
        end
        line_total = counted;
        if (line_total == 0) begin
            $display("Trace file is missing or empty, nothing was run");
            $display("RESULT: FAIL");
            $finish;
        end else begin
            wait (reset_n === 1'b1);
            for (row = 0; row < line_total; row++) begin
                @(posedge clock);
                drive_inputs(row);
                // Falling edge, registers and decode settled
                @(negedge clock);
                current_test = int'(trace_field(row, 0));
                test_cycles++;
                check_outputs(row);
                if (row == line_total - 1 || trace_field(row + 1, 0) != trace_field(row, 0)) begin
                    $display("Test %0d finished, %0d cycles, %0d errors",
                             current_test, test_cycles, test_errors);
                    tests_done++;
                    test_cycles = 0;
                    test_errors = 0;
                end
            end
            $display("Tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
            if (errors == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

    // Watchdog sized from the trace length plus slack
    initial begin
        wait (line_total > 0);
        #((line_total + 20) * 10);
        $display("Watchdog expired, the trace did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/floor_trace.txt
// test call panel door_open door_close emergency power floor car_state car_dir (inputs, hex)
// then expected call_lights panel_lights target activate direction door_open door_close
01 000 000 0 0 0 1 0 00 0   000 000 0 0 0 0 0
01 001 001 0 0 0 1 0 00 0   000 000 0 0 0 0 0
01 000 000 0 0 0 1 0 00 0   000 000 0 0 0 0 0
02 000 020 0 0 0 1 0 00 0   000 000 0 0 0 0 0
02 000 000 0 0 0 1 0 00 0   000 020 0 0 0 0 0
02 000 000 0 0 0 1 0 00 0   000 020 5 1 1 0 0
02 000 000 1 1 0 1 0 0b 1   000 020 5 0 1 0 0
02 000 000 0 0 0 1 5 05 1   000 020 5 0 1 0 0
03 080 000 0 0 0 1 5 05 1   000 000 5 0 1 0 0
03 004 000 0 0 0 1 5 05 1   080 000 5 0 1 0 0
03 200 000 0 0 0 1 5 05 1   084 000 7 1 1 0 0
03 000 000 0 0 0 1 5 10 1   284 000 7 0 1 0 0
03 000 000 0 0 0 1 7 07 1   284 000 7 0 1 0 0
03 000 000 0 0 0 1 7 07 1   204 000 7 0 1 0 0
03 000 000 0 0 0 1 7 07 1   204 000 2 1 0 0 0
03 000 000 0 0 0 1 2 02 0   204 000 2 0 0 0 0
03 000 000 0 0 0 1 2 02 0   200 000 2 0 0 0 0
03 000 000 0 0 0 1 2 02 0   200 000 9 1 1 0 0
03 000 000 0 0 0 1 9 09 1   200 000 9 0 1 0 0
04 008 008 0 0 0 1 9 09 1   000 000 9 0 1 0 0
04 008 008 0 0 0 1 9 09 1   000 008 9 0 1 0 0
04 000 000 0 0 0 1 9 09 0   008 008 3 1 0 0 0
04 000 000 0 0 0 1 3 03 0   008 008 3 0 0 0 0
04 000 040 0 0 0 1 3 03 0   000 000 3 0 0 0 0
04 000 000 0 0 0 1 3 03 0   000 040 3 0 0 0 0
04 000 000 0 0 0 1 3 03 0   000 040 6 1 1 0 0
05 400 000 0 0 1 1 3 03 1   000 040 6 0 1 0 0
05 000 002 0 0 0 1 3 03 1   000 000 6 1 1 0 0
05 000 000 0 0 0 0 3 03 1   000 002 6 0 1 0 0
05 000 010 0 0 0 1 3 03 1   000 000 6 1 1 0 0
05 000 000 0 0 0 1 3 03 1   000 010 6 1 1 0 0
05 000 000 0 0 0 1 3 03 1   000 010 4 1 1 0 0
06 000 000 1 0 0 1 3 03 1   000 010 4 1 1 1 0
06 000 000 0 1 0 1 3 03 1   000 010 4 1 1 0 1
06 000 000 1 1 0 1 3 0e 0   000 010 4 0 0 0 0
06 000 000 1 1 1 1 3 03 1   000 010 4 0 1 0 0
06 000 000 1 1 0 1 3 1f 0   000 000 4 0 0 0 0
